//--- verilog/dbg_map_pkg.sv
// debug status map: page and field codes plus vu meter constants
package dbg_map_pkg;

    // st_addr[7:6] selects the page
    localparam logic [1:0] page_frame = 2'd0;
    localparam logic [1:0] page_sound = 2'd1;
    localparam logic [1:0] page_sdram = 2'd2;
    localparam logic [1:0] page_input = 2'd3;

    // st_addr[5:4] selects the subpage inside the sound page
    localparam logic [1:0] sub_vu   = 2'd0;
    localparam logic [1:0] sub_chan = 2'd1;
    localparam logic [1:0] sub_vol  = 2'd2;
    localparam logic [1:0] sub_sys  = 2'd3;

    // magnitude at or above this raises the peak flag
    localparam logic [15:0] vu_peak_level = 16'h7f00;

    // approx dB per magnitude bit
    localparam logic [7:0] vu_db_step = 8'd6;

endpackage

//--- verilog/dbg_sig_pkg.sv
// debug status input bundles for sound, control and pointer signals
package dbg_sig_pkg;

    // sound side inputs
    typedef struct packed {
        logic               sample;     // sample strobe
        logic        [ 7:0] vol;
        logic        [ 5:0] en;         // channel enables
        logic        [ 5:0] vu;         // channel activity
        logic signed [15:0] l;
        logic signed [15:0] r;
    } snd_in_t;

    // core control, dip switches and load flags
    typedef struct packed {
        logic        dip_pause;         // high while the game runs
        logic        dip_flip;
        logic        game_led;
        logic [ 6:0] core_mod;
        logic [ 3:0] gfx_en;
        logic [23:0] dipsw;
        logic        ioctl_ram;
        logic        ioctl_rom;
        logic        ioctl_cart;
    } ctrl_in_t;

    // dial and mouse
    typedef struct packed {
        logic [1:0] dial_x;
        logic [8:0] dx;
        logic [8:0] dy;
        logic [7:0] flags;
    } ptr_in_t;

endpackage

//--- verilog/bcd_cnt.sv
// decimal up counter with configurable digit count and wrap or saturate at all nines
`timescale 1ns/100ps

module bcd_cnt #(
    parameter int digits = 2,
    parameter bit wrap   = 1'b1     // 0 holds at all nines
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    input  logic                  up,
    output logic [4*digits-1:0]   cnt
);

    logic [4*digits-1:0] nxt;
    logic                carry;

    // ripple the decimal carry from the low digit upwards
    always_comb begin
        carry = up;
        nxt   = cnt;
        for (int k = 0; k < digits; k++) begin
            if (carry) begin
                if (cnt[4*k +: 4] == 4'd9) begin
                    nxt[4*k +: 4] = 4'd0;   // carry keeps going
                end else begin
                    nxt[4*k +: 4] = cnt[4*k +: 4] + 4'd1;
                    carry         = 1'b0;
                end
            end
        end
        if (carry && !wrap) nxt = cnt; // all nines, hold
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else begin
            cnt <= nxt;
        end
    end

    for (genvar g = 0; g < digits; g++) begin : g_digit_chk
        a_digit_range: assert property (@(posedge clk) disable iff (rst)
            cnt[4*g +: 4] <= 4'd9);
    end

endmodule

//--- verilog/sdram_stats.sv
// per-frame count of SDRAM bank ready pulses, shown for the previous frame
`timescale 1ns/100ps

module sdram_stats (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] rdy,
    input  logic       lvbl,
    input  logic [1:0] sel,
    output logic [7:0] dout
);

    logic [7:0] run_cnt   [4];
    logic [7:0] shown_cnt [4];
    logic       lvbl_l;
    logic       frame_start;

    assign frame_start = lvbl_l & ~lvbl;   // start of vertical blank

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
        end
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                run_cnt[b]   <= 8'd0;
                shown_cnt[b] <= 8'd0;
            end else if (frame_start) begin
                shown_cnt[b] <= run_cnt[b];
                run_cnt[b]   <= 8'd0;
            end else if (rdy[b] && run_cnt[b] != 8'hff) begin
                run_cnt[b] <= run_cnt[b] + 8'd1;   // stops at 255
            end
        end

        // running count only restarts at a frame start and never wraps
        a_run_hold: assert property (@(posedge clk) disable iff (rst)
            !$past(frame_start) |-> run_cnt[b] >= $past(run_cnt[b]));
    end

    assign dout = shown_cnt[sel];

endmodule

//--- verilog/vumeter.sv
// stereo peak hold meter with periodic decay, dB readout and peak flag
`timescale 1ns/100ps

module vumeter (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic signed [15:0] l,
    input  logic signed [15:0] r,
    output logic        [ 7:0] vu,
    output logic               peak
);

    logic [15:0] mag;           // held magnitude
    logic [15:0] mag_l;
    logic [15:0] mag_r;
    logic [15:0] mag_max;
    logic [ 7:0] decay_cnt;

    // -32768 comes out as 16'h8000, which is still correct unsigned
    function automatic logic [15:0] abs16(input logic signed [15:0] s);
        logic [15:0] u;
        u = s;
        return s[15] ? ~u + 16'd1 : u;
    endfunction

    // step times (msb index + 1)
    function automatic logic [7:0] to_db(input logic [15:0] m);
        logic [7:0] v;
        v = 8'd0;
        for (int i = 0; i < 16; i++) begin
            if (m[i]) v = dbg_map_pkg::vu_db_step * 8'(i + 1);
        end
        return v;
    endfunction

    assign mag_l = abs16(l);
    assign mag_r = abs16(r);

    always_comb begin
        mag_max = mag;
        if (mag_l > mag_max) mag_max = mag_l;
        if (mag_r > mag_max) mag_max = mag_r;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mag       <= 16'd0;
            decay_cnt <= 8'd0;
        end else if (cen) begin
            decay_cnt <= decay_cnt + 8'd1;
            if (decay_cnt == 8'hff) begin
                mag <= mag >> 1;    // halve every 256 samples
            end else begin
                mag <= mag_max;
            end
        end
    end

    assign vu   = to_db(mag);
    assign peak = mag >= dbg_map_pkg::vu_peak_level;

endmodule

//--- verilog/sys_info.sv
// system statistics collector and registered status byte readout
`timescale 1ns/100ps

module sys_info #(
    parameter int mfreq = 48000     // clock cycles per millisecond
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lvbl,
    input  dbg_sig_pkg::snd_in_t  snd,
    input  dbg_sig_pkg::ctrl_in_t ctrl,
    input  dbg_sig_pkg::ptr_in_t  ptr,
    input  logic [3:0]            ba_rdy,
    input  logic [7:0]            st_addr,
    output logic [7:0]            st_dout,
    output logic                  snd_mode,
    output logic                  vu_peak
);

    localparam int win_w = $clog2(mfreq);

    logic [19:0]      frame_bcd;
    logic             frame_up;
    logic             lvbl_l;
    logic [win_w-1:0] win_cnt;      // millisecond window
    logic             win_end;
    logic             sample_l;
    logic             sample_up;
    logic [ 7:0]      scnt;
    logic [ 7:0]      srate;
    logic [ 7:0]      stats;
    logic [ 7:0]      vu_db;

    assign frame_up  = lvbl & ~lvbl_l & ctrl.dip_pause;
    assign sample_up = snd.sample & ~sample_l;
    assign win_end   = win_cnt == win_w'(mfreq - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b0;
            sample_l <= 1'b0;
            win_cnt  <= '0;
            srate    <= 8'd0;
        end else begin
            lvbl_l   <= lvbl;
            sample_l <= snd.sample;
            win_cnt  <= win_cnt + 1'd1;
            if (win_end) begin
                win_cnt <= '0;
                srate   <= scnt;    // samples in the last ms = kHz
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_dout  <= 8'd0;
            snd_mode <= 1'b0;
        end else begin
            st_dout  <= 8'd0;
            snd_mode <= 1'b0;
            case (st_addr[7:6])
                dbg_map_pkg::page_frame: begin
                    case (st_addr[1:0])
                        2'd0: st_dout <= frame_bcd[15:8];
                        2'd1: st_dout <= frame_bcd[7:0];
                        2'd2: st_dout <= {4'd0, frame_bcd[19:16]};
                        default: st_dout <= 8'd0;
                    endcase
                end
                dbg_map_pkg::page_sound: begin
                    snd_mode <= st_addr[5:4] != dbg_map_pkg::sub_sys;
                    case (st_addr[5:4])
                        dbg_map_pkg::sub_vu:  st_dout <= vu_db;
                        dbg_map_pkg::sub_chan: begin
                            case (st_addr[1:0])
                                2'd0: st_dout <= {2'd0, snd.vu & snd.en}; // active and on
                                2'd1: st_dout <= {2'd0, snd.en};
                                2'd2: st_dout <= srate;
                                default: st_dout <= 8'd0;
                            endcase
                        end
                        dbg_map_pkg::sub_vol: st_dout <= snd.vol;
                        dbg_map_pkg::sub_sys: begin
                            if (st_addr[3:2] == 2'd0) begin
                                // layer enables shown msb first
                                st_dout <= {ctrl.gfx_en[0], ctrl.gfx_en[1], ctrl.gfx_en[2],
                                            ctrl.gfx_en[3], 1'b0, ctrl.ioctl_ram,
                                            ctrl.ioctl_cart, ctrl.ioctl_rom};
                            end else if (st_addr[3:2] == 2'd1 && st_addr[1:0] != 2'd3) begin
                                st_dout <= ctrl.dipsw[8*st_addr[1:0] +: 8];
                            end
                        end
                    endcase
                end
                dbg_map_pkg::page_sdram: st_dout <= stats;
                dbg_map_pkg::page_input: begin
                    case (st_addr[5:4])
                        2'd0: st_dout <= {ctrl.core_mod[3:0], ptr.dial_x,
                                          ctrl.game_led, ctrl.dip_flip};
                        2'd1: st_dout <= ptr.dx[8:1];
                        2'd2: st_dout <= ptr.dy[8:1];
                        2'd3: st_dout <= ptr.flags;
                    endcase
                end
            endcase
        end
    end

    // the sample count holds at 99 until the window end clears it
    a_scnt_sat: assert property (@(posedge clk) disable iff (rst)
        scnt == 8'h99 && !win_end |=> scnt == 8'h99);

    bcd_cnt #(.digits(5), .wrap(1'b1)) u_frame_cnt (
        .clk (clk),
        .rst (rst),
        .clr (1'b0),
        .up  (frame_up),
        .cnt (frame_bcd)
    );

    bcd_cnt #(.digits(2), .wrap(1'b0)) u_sample_cnt (
        .clk (clk),
        .rst (rst),
        .clr (win_end),
        .up  (sample_up),
        .cnt (scnt)
    );

    sdram_stats u_stats (
        .clk  (clk),
        .rst  (rst),
        .rdy  (ba_rdy),
        .lvbl (lvbl),
        .sel  (st_addr[1:0]),
        .dout (stats)
    );

    vumeter u_vumeter (
        .clk  (clk),
        .rst  (rst),
        .cen  (snd.sample),
        .l    (snd.l),
        .r    (snd.r),
        .vu   (vu_db),
        .peak (vu_peak)
    );

endmodule

//--- verilog/dbg_status_top.sv
// debug status readout top level, sets the window length for sys_info
`timescale 1ns/100ps

module dbg_status_top #(
    parameter int mfreq = 48000     // 48 MHz clock
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lvbl,
    input  dbg_sig_pkg::snd_in_t  snd,
    input  dbg_sig_pkg::ctrl_in_t ctrl,
    input  dbg_sig_pkg::ptr_in_t  ptr,
    input  logic [3:0]            ba_rdy,
    input  logic [7:0]            st_addr,
    output logic [7:0]            st_dout,
    output logic                  snd_mode,
    output logic                  vu_peak
);

    sys_info #(.mfreq(mfreq)) u_sys_info (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (lvbl),
        .snd      (snd),
        .ctrl     (ctrl),
        .ptr      (ptr),
        .ba_rdy   (ba_rdy),
        .st_addr  (st_addr),
        .st_dout  (st_dout),
        .snd_mode (snd_mode),
        .vu_peak  (vu_peak)
    );

endmodule

//--- testbench/tb_sys_info.sv
// debug status readout testbench, applies address rows and compares the status byte
`timescale 1ns/100ps

module tb_sys_info;

    localparam int mfreq = 400;             // short ms window

    localparam logic [3:0] snd_vu   = {dbg_map_pkg::page_sound, dbg_map_pkg::sub_vu};
    localparam logic [3:0] snd_chan = {dbg_map_pkg::page_sound, dbg_map_pkg::sub_chan};
    localparam logic [3:0] snd_vol  = {dbg_map_pkg::page_sound, dbg_map_pkg::sub_vol};
    localparam logic [3:0] snd_sys  = {dbg_map_pkg::page_sound, dbg_map_pkg::sub_sys};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  lvbl;
    dbg_sig_pkg::snd_in_t  snd;
    dbg_sig_pkg::ctrl_in_t ctrl;
    dbg_sig_pkg::ptr_in_t  ptr;
    logic [3:0]            ba_rdy;
    logic [7:0]            st_addr;
    logic [7:0]            st_dout;
    logic                  snd_mode;
    logic                  vu_peak;

    dbg_sig_pkg::snd_in_t  snd_val;         // random field values
    dbg_sig_pkg::ctrl_in_t ctrl_val;
    dbg_sig_pkg::ptr_in_t  ptr_val;
    integer                seed;
    logic [159:0]          rnd;
    logic                  exp_mode;
    int                    errors;
    int                    rows;
    string                 row_name  [24];
    logic [7:0]            row_addr  [24];
    int                    row_setup [24];
    logic [7:0]            row_exp   [24];

    dbg_status_top #(.mfreq(mfreq)) DUT (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %02h actual %02h", name, expected, actual);
            errors++;
        end
    endtask

    // bit order of a nibble turned around
    function automatic logic [3:0] reverse_nibble(input logic [3:0] v);
        logic [3:0] r;
        for (int k = 0; k < 4; k++) begin
            r[k] = v[3-k];
        end
        return r;
    endfunction

    task automatic add_row(input string name, input logic [7:0] addr, input int setup,
                           input logic [7:0] expected);
        row_name[rows]  = name;
        row_addr[rows]  = addr;
        row_setup[rows] = setup;
        row_exp[rows]   = expected;
        rows++;
    endtask

    // count moves on the rising edge of lvbl
    task automatic frame_pulses(input int n, input logic pause);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            ctrl.dip_pause <= pause;
            lvbl           <= 1'b0;
            repeat (2) @(posedge clk);
            lvbl <= 1'b1;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic sample_pulse(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            snd.sample <= 1'b1;
            @(posedge clk);
            snd.sample <= 1'b0;
        end
    endtask

    task automatic run_setup(input int code);
        int waited;
        case (code)
            1: begin
                frame_pulses(12, 1'b1);
                frame_pulses(3, 1'b0);          // paused frames
            end
            2: begin
                for (int i = 0; i < 3 * mfreq; i++) begin
                    @(posedge clk);
                    snd.sample <= ~snd.sample;  // rising edge every other cycle
                end
            end
            3: repeat (3 * mfreq) @(posedge clk);
            4: begin
                @(posedge clk);
                lvbl <= 1'b0;                   // frame start restarts running counts
                for (int i = 0; i < 300; i++) begin
                    @(posedge clk);
                    ba_rdy <= {1'b0, 1'b1, i < 7, 1'b0};
                end
                @(posedge clk);
                ba_rdy <= 4'd0;
                lvbl   <= 1'b1;
                repeat (4) @(posedge clk);
                lvbl <= 1'b0;                   // latch into the shown counts
            end
            5: begin
                @(posedge clk);
                rst <= 1'b1;                    // fresh decay count
                @(posedge clk);
                rst   <= 1'b0;
                snd.l <= 16'sd1000;
                sample_pulse(3);
                @(negedge clk);
                check_value("vu_peak_low", 8'd0, {7'd0, vu_peak});
            end
            6: begin
                @(posedge clk);
                snd.r <= 16'sh8000;             // most negative sample
                sample_pulse(1);
                waited = 0;
                while (!vu_peak && waited < 16) begin
                    @(negedge clk);
                    waited++;
                end
                if (!vu_peak) begin
                    $display("timed out waiting for vu_peak after a full scale sample");
                    errors++;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        seed   = 32'h327f_bc02;
        errors = 0;
        rows   = 0;
        rnd    = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        {ctrl_val, snd_val, ptr_val} = rnd[121:0];
        ctrl_val.dip_pause = 1'b0;
        snd_val.sample     = 1'b0;
        snd_val.l          = 16'sd0;
        snd_val.r          = 16'sd0;
        rst     <= 1'b1;
        lvbl    <= 1'b1;
        snd     <= snd_val;
        ctrl    <= ctrl_val;
        ptr     <= ptr_val;
        ba_rdy  <= 4'd0;
        st_addr <= 8'd0;

        add_row("dipsw_byte0", {snd_sys, 4'h4}, 0, ctrl_val.dipsw[7:0]);
        add_row("dipsw_byte1", {snd_sys, 4'h5}, 0, ctrl_val.dipsw[15:8]);
        add_row("dipsw_byte2", {snd_sys, 4'h6}, 0, ctrl_val.dipsw[23:16]);
        add_row("dipsw_unused", {snd_sys, 4'h7}, 0, 8'h00);
        add_row("gfx_ioctl", {snd_sys, 4'h0}, 0,
                {reverse_nibble(ctrl_val.gfx_en), 1'b0, ctrl_val.ioctl_ram,
                 ctrl_val.ioctl_cart, ctrl_val.ioctl_rom});
        add_row("volume", {snd_vol, 4'h0}, 0, snd_val.vol);
        add_row("chan_en", {snd_chan, 4'h1}, 0, {2'b00, snd_val.en});
        add_row("chan_active", {snd_chan, 4'h0}, 0, {2'b00, snd_val.vu & snd_val.en});
        add_row("chan_unused", {snd_chan, 4'h3}, 0, 8'h00);
        add_row("core_dial", {dbg_map_pkg::page_input, 6'h00}, 0,
                {ctrl_val.core_mod[3:0], ptr_val.dial_x, ctrl_val.game_led, ctrl_val.dip_flip});
        add_row("mouse_dx", {dbg_map_pkg::page_input, 6'h10}, 0, ptr_val.dx[8:1]);
        add_row("mouse_dy", {dbg_map_pkg::page_input, 6'h20}, 0, ptr_val.dy[8:1]);
        add_row("mouse_flags", {dbg_map_pkg::page_input, 6'h30}, 0, ptr_val.flags);
        add_row("frame_low", {dbg_map_pkg::page_frame, 6'h01}, 1, 8'h12);
        add_row("frame_mid", {dbg_map_pkg::page_frame, 6'h00}, 0, 8'h00);
        add_row("frame_top", {dbg_map_pkg::page_frame, 6'h02}, 0, 8'h00);
        add_row("srate_full", {snd_chan, 4'h2}, 2, 8'h99);
        add_row("srate_idle", {snd_chan, 4'h2}, 3, 8'h00);
        add_row("sdram_bank1", {dbg_map_pkg::page_sdram, 6'h01}, 4, 8'd7);
        add_row("sdram_bank2", {dbg_map_pkg::page_sdram, 6'h02}, 0, 8'd255);
        add_row("sdram_bank0", {dbg_map_pkg::page_sdram, 6'h00}, 0, 8'd0);
        add_row("vu_mid", {snd_vu, 4'h0}, 5, dbg_map_pkg::vu_db_step * 8'd10);  // msb 9
        add_row("vu_full", {snd_vu, 4'h0}, 6, dbg_map_pkg::vu_db_step * 8'd16); // msb 15

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rows; i++) begin
            run_setup(row_setup[i]);
            @(posedge clk);
            st_addr <= row_addr[i];
            @(posedge clk);
            @(negedge clk);                     // one cycle after the address
            exp_mode = row_addr[i][7:6] == dbg_map_pkg::page_sound &&
                       row_addr[i][5:4] != dbg_map_pkg::sub_sys;
            check_value(row_name[i], row_exp[i], st_dout);
            check_value({row_name[i], "_snd_mode"}, {7'd0, exp_mode}, {7'd0, snd_mode});
        end

        $display("status readout checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/dbg_map_pkg.sv
verilog/dbg_sig_pkg.sv
verilog/bcd_cnt.sv
verilog/sdram_stats.sv
verilog/vumeter.sv
verilog/sys_info.sv
verilog/dbg_status_top.sv
testbench/tb_sys_info.sv
